// ==== logic/cache_cfg_pkg.sv ====
// Data cache request path configuration
// Geometry of addresses, lines and store words, plus queue and credit sizing
package cache_cfg_pkg;

    // Address and data widths
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 64;

    // Line and store granule, in bytes
    localparam int unsigned LINE_BYTES = 32;
    localparam int unsigned WORD_BYTES = 8;

    // Offset bits cleared by the request builder
    localparam int unsigned LINE_OFFSET = $clog2(LINE_BYTES);
    localparam int unsigned WORD_OFFSET = $clog2(WORD_BYTES);

    // Read transaction identifier
    localparam int unsigned ID_WIDTH = 2;

    // Request queue depth
    localparam int unsigned REQ_FIFO_DEPTH = 4;

    // Refill credits, count runs from zero to MAX_READS_OUT inclusive
    localparam int unsigned MAX_READS_OUT = 2;
    localparam int unsigned CREDIT_WIDTH = $clog2(MAX_READS_OUT + 1);

endpackage

// ==== logic/mem_req_pkg.sv ====
// Memory request types
// Request kinds, the two-way payload word, and the core and memory requests
package mem_req_pkg;

    import cache_cfg_pkg::*;

    // Request kind, one bit
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_e;

    // Read view of the payload word
    // Identifier sits in the low bits, the rest is zero
    typedef struct packed {
        logic [DATA_WIDTH-ID_WIDTH-1:0] pad;
        logic [ID_WIDTH-1:0]            id;
    } rd_view_t;

    // One payload word, decoded by request kind
    typedef union packed {
        rd_view_t               rd;
        logic [DATA_WIDTH-1:0]  wr_data;
    } mem_payload_u;

    // Core side request, valid is a plain strobe
    typedef struct packed {
        logic                   valid;
        req_kind_e              kind;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  data;
    } core_req_t;

    // Queue entry and memory request
    // Address already aligned for its kind
    typedef struct packed {
        req_kind_e              kind;
        logic [ADDR_WIDTH-1:0]  addr;
        mem_payload_u           payload;
    } mem_req_t;

endpackage

// ==== logic/miss_req_builder.sv ====
// Miss request builder
// Aligns core request addresses, tags reads with a transaction identifier
// and pushes the resulting entry into the request queue
`timescale 1ns/100ps

module miss_req_builder (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  mem_req_pkg::core_req_t core_req_i,
    output logic                  core_ready_o,
    input  logic                  fifo_wok_i,
    output logic                  fifo_w_o,
    output mem_req_pkg::mem_req_t fifo_wdata_o
);

    import cache_cfg_pkg::*;
    import mem_req_pkg::*;

    logic [ID_WIDTH-1:0]   rd_id_q;
    logic                  is_read;
    logic                  accept;
    logic [ADDR_WIDTH-1:0] line_addr;
    logic [ADDR_WIDTH-1:0] word_addr;

    // Queue space is the only thing that stalls the core
    assign core_ready_o = fifo_wok_i;
    assign fifo_w_o     = core_req_i.valid;

    // Request taken when strobe and space meet
    assign accept  = core_req_i.valid & fifo_wok_i;
    assign is_read = (core_req_i.kind == REQ_READ);

    // Refill starts at the line base
    assign line_addr = {core_req_i.addr[ADDR_WIDTH-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}};
    // Stores keep their word address
    assign word_addr = {core_req_i.addr[ADDR_WIDTH-1:WORD_OFFSET], {WORD_OFFSET{1'b0}}};

    // Entry assembly
    always_comb begin
        fifo_wdata_o      = '0;
        fifo_wdata_o.kind = core_req_i.kind;
        if (is_read) begin
            fifo_wdata_o.addr               = line_addr;
            // Read view, identifier with zero padding
            fifo_wdata_o.payload.rd.pad     = '0;
            fifo_wdata_o.payload.rd.id      = rd_id_q;
        end else begin
            fifo_wdata_o.addr               = word_addr;
            // Write view carries the raw store word
            fifo_wdata_o.payload.wr_data    = core_req_i.data;
        end
    end

    // Identifier counter
    // Wraps naturally, moves only on accepted reads
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_id_q <= '0;
        end else if (accept && is_read) begin
            rd_id_q <= rd_id_q + 1'b1;
        end
    end

endmodule

// ==== logic/req_fifo_reg.sv ====
// Register based FIFO
// Write and read pointers plus a crossover bit tell full from empty,
// head entry is read combinationally from the register array
`timescale 1ns/100ps

module req_fifo_reg #(
    parameter int unsigned FIFO_DEPTH  = 4,
    parameter type         fifo_data_t = logic
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       w_i,
    output logic       wok_o,
    input  fifo_data_t wdata_i,
    input  logic       r_i,
    output logic       rok_o,
    output fifo_data_t rdata_o
);

    // Pointer width, at least one bit
    localparam int unsigned PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    typedef logic [PTR_WIDTH-1:0] ptr_t;

    localparam ptr_t PTR_LAST = ptr_t'(FIFO_DEPTH - 1);

    // Storage, no reset
    fifo_data_t [FIFO_DEPTH-1:0] mem_q;

    ptr_t rptr_q;
    ptr_t rptr_d;
    ptr_t wptr_q;
    ptr_t wptr_d;
    // Set once the write pointer has wrapped ahead of the read pointer
    logic crossover_q;
    logic crossover_d;

    logic ptr_eq;
    logic rexec;
    logic wexec;
    logic rptr_wrap;
    logic wptr_wrap;

    // Status levels
    // Equal pointers mean full with crossover, empty without
    assign ptr_eq = (rptr_q == wptr_q);
    assign rok_o  = ptr_eq ? crossover_q : 1'b1;
    assign wok_o  = ptr_eq ? ~crossover_q : 1'b1;

    // Effective operations
    assign rexec = r_i & rok_o;
    assign wexec = w_i & wok_o;

    // Last slot reached
    assign rptr_wrap = (rptr_q == PTR_LAST);
    assign wptr_wrap = (wptr_q == PTR_LAST);

    // Next pointer values
    always_comb begin
        rptr_d = rptr_q;
        wptr_d = wptr_q;
        if (rexec) begin
            rptr_d = rptr_wrap ? '0 : rptr_q + 1'b1;
        end
        if (wexec) begin
            wptr_d = wptr_wrap ? '0 : wptr_q + 1'b1;
        end
    end

    // Crossover tracking
    // Read wrap clears it, write wrap sets it
    always_comb begin
        crossover_d = crossover_q;
        if (rexec && rptr_wrap) begin
            crossover_d = 1'b0;
        end else if (wexec && wptr_wrap) begin
            crossover_d = 1'b1;
        end
    end

    // Array write
    always_ff @(posedge clk_i) begin
        if (wexec) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

    // Head visible in the same cycle
    assign rdata_o = mem_q[rptr_q];

    // Control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rptr_q      <= '0;
            wptr_q      <= '0;
            crossover_q <= 1'b0;
        end else begin
            rptr_q      <= rptr_d;
            wptr_q      <= wptr_d;
            crossover_q <= crossover_d;
        end
    end

endmodule

// ==== logic/mem_req_issuer.sv ====
// Memory request issuer
// Drains the request queue in order toward memory, holding read heads back
// while no refill credit is free
`timescale 1ns/100ps

module mem_req_issuer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  fifo_rok_i,
    input  mem_req_pkg::mem_req_t fifo_rdata_i,
    output logic                  fifo_r_o,
    output logic                  mem_valid_o,
    output mem_req_pkg::mem_req_t mem_req_o,
    input  logic                  mem_ready_i,
    input  logic                  mem_rsp_i
);

    import cache_cfg_pkg::*;
    import mem_req_pkg::*;

    localparam logic [CREDIT_WIDTH-1:0] CREDITS_ALL = CREDIT_WIDTH'(MAX_READS_OUT);

    // Free refill credits
    logic [CREDIT_WIDTH-1:0] credits_q;

    logic head_is_read;
    logic head_blocked;
    logic xfer;
    logic rd_xfer;

    assign head_is_read = (fifo_rdata_i.kind == REQ_READ);

    // Reads need a credit, writes never wait on one
    // A blocked read also holds every write queued behind it
    assign head_blocked = head_is_read && (credits_q == '0);

    assign mem_valid_o = fifo_rok_i & ~head_blocked;
    // Head goes out untouched
    assign mem_req_o   = fifo_rdata_i;

    // Pop exactly on a memory transfer
    assign xfer     = mem_valid_o & mem_ready_i;
    assign fifo_r_o = xfer;
    assign rd_xfer  = xfer & head_is_read;

    // Credit accounting
    // Issued read takes one, response returns one, both together cancel
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credits_q <= CREDITS_ALL;
        end else begin
            case ({rd_xfer, mem_rsp_i})
                2'b10: begin
                    credits_q <= credits_q - 1'b1;
                end
                2'b01: begin
                    // Saturate, a spurious response must not overflow
                    if (credits_q != CREDITS_ALL) begin
                        credits_q <= credits_q + 1'b1;
                    end
                end
                default: begin
                    credits_q <= credits_q;
                end
            endcase
        end
    end

endmodule

// ==== logic/miss_req_top.sv ====
// Miss and write-through request path
// Builder feeds the request queue, issuer drains it to the memory port
`timescale 1ns/100ps

module miss_req_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  mem_req_pkg::core_req_t core_req_i,
    output logic                   core_ready_o,
    output logic                   mem_valid_o,
    output mem_req_pkg::mem_req_t  mem_req_o,
    input  logic                   mem_ready_i,
    input  logic                   mem_rsp_i
);

    import cache_cfg_pkg::*;
    import mem_req_pkg::*;

    // Builder to queue
    logic     fifo_w;
    logic     fifo_wok;
    mem_req_t fifo_wdata;

    // Queue to issuer
    logic     fifo_r;
    logic     fifo_rok;
    mem_req_t fifo_rdata;

    miss_req_builder i_builder (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .core_req_i   (core_req_i),
        .core_ready_o (core_ready_o),
        .fifo_wok_i   (fifo_wok),
        .fifo_w_o     (fifo_w),
        .fifo_wdata_o (fifo_wdata)
    );

    // Request queue
    req_fifo_reg #(
        .FIFO_DEPTH  (REQ_FIFO_DEPTH),
        .fifo_data_t (mem_req_t)
    ) i_req_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (fifo_w),
        .wok_o   (fifo_wok),
        .wdata_i (fifo_wdata),
        .r_i     (fifo_r),
        .rok_o   (fifo_rok),
        .rdata_o (fifo_rdata)
    );

    mem_req_issuer i_issuer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .fifo_rok_i   (fifo_rok),
        .fifo_rdata_i (fifo_rdata),
        .fifo_r_o     (fifo_r),
        .mem_valid_o  (mem_valid_o),
        .mem_req_o    (mem_req_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rsp_i    (mem_rsp_i)
    );

endmodule

// ==== sim/req_fifo_asserts.sv ====
// Register FIFO assertions
// Status levels, guarded writes and pointer ordering, bound into every req_fifo_reg
`timescale 1ns/100ps

module req_fifo_asserts #(
    parameter int unsigned FIFO_DEPTH = 4,
    parameter int unsigned PTR_WIDTH  = 2
) (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 w_i,
    input logic                 wok_i,
    input logic                 r_i,
    input logic                 rok_i,
    input logic [PTR_WIDTH-1:0] rptr_i,
    input logic [PTR_WIDTH-1:0] wptr_i,
    input logic                 crossover_i
);

    localparam int unsigned CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Occupancy seen from the strobes alone
    logic [CNT_WIDTH-1:0] fill_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fill_q <= '0;
        end else begin
            fill_q <= fill_q + CNT_WIDTH'(w_i && wok_i) - CNT_WIDTH'(r_i && rok_i);
        end
    end

    // Data present and space free follow the occupancy, never both low
    a_status_levels: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (rok_i == (fill_q != '0)) && (wok_i == (fill_q != CNT_WIDTH'(FIFO_DEPTH)))
    ) else $error("FIFO status levels disagree with its occupancy");

    // Full queue ignores the write strobe
    a_no_write_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (w_i && !wok_i) |=> $stable(wptr_i)
    ) else $error("FIFO write pointer moved while full");

    // Without crossover the reader trails, with it the writer has wrapped
    a_ptr_order: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        crossover_i ? (rptr_i >= wptr_i) : (rptr_i <= wptr_i)
    ) else $error("FIFO read pointer passed the write pointer");

endmodule

bind req_fifo_reg req_fifo_asserts #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .PTR_WIDTH  (PTR_WIDTH)
) i_fifo_asserts (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .w_i         (w_i),
    .wok_i       (wok_o),
    .r_i         (r_i),
    .rok_i       (rok_o),
    .rptr_i      (rptr_q),
    .wptr_i      (wptr_q),
    .crossover_i (crossover_q)
);

// ==== sim/miss_req_tb.sv ====
// Testbench for the miss and write-through request path
// Random core requests, memory stalls and responses, checked against a queue model
`timescale 1ns/100ps

module miss_req_tb;

    import cache_cfg_pkg::*;
    import mem_req_pkg::*;

    localparam int unsigned CLK_HALF     = 2;
    localparam int unsigned RESET_CYCLES = 5;
    localparam int unsigned NUM_REQS     = 400;
    // Worst case per request, long memory stalls included
    localparam int unsigned WORST_CYCLES_PER_REQ = 50;
    localparam int unsigned TIMEOUT_NS =
        (NUM_REQS * WORST_CYCLES_PER_REQ + 4 * RESET_CYCLES) * 2 * CLK_HALF;

    logic      clk_i;
    logic      rst_ni;
    core_req_t core_req;
    logic      core_ready;
    logic      mem_valid;
    mem_req_t  mem_req;
    logic      mem_ready;
    logic      mem_rsp;

    // Reference model state
    mem_req_t    exp_q[$];
    int unsigned free_credits;
    int unsigned next_id;
    int unsigned accepted;
    int unsigned issued;
    int unsigned stall_left;
    logic        req_taken;

    miss_req_top i_dut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .core_req_i   (core_req),
        .core_ready_o (core_ready),
        .mem_valid_o  (mem_valid),
        .mem_req_o    (mem_req),
        .mem_ready_i  (mem_ready),
        .mem_rsp_i    (mem_rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_HALF) clk_i = ~clk_i;
    end

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Expected queue entry for an accepted core request
    function automatic mem_req_t build_entry(input core_req_t req, input int unsigned id);
        mem_req_t e;
        e.kind = req.kind;
        if (req.kind == REQ_READ) begin
            // Line base, identifier in the low payload bits
            e.addr    = req.addr & ~ADDR_WIDTH'(LINE_BYTES - 1);
            e.payload = DATA_WIDTH'(id);
        end else begin
            e.addr    = req.addr & ~ADDR_WIDTH'(WORD_BYTES - 1);
            e.payload = req.data;
        end
        return e;
    endfunction

    // Mid-cycle sample, compare and model update for the coming edge
    task automatic check_cycle();
        logic     exp_ready;
        logic     exp_valid;
        logic     head_read;
        logic     xfer;
        mem_req_t head;
        exp_ready = (exp_q.size() != REQ_FIFO_DEPTH);
        check_equal(64'(core_ready), 64'(exp_ready), "core_ready_o against model fill level");
        exp_valid = 1'b0;
        head_read = 1'b0;
        head      = '0;
        if (exp_q.size() != 0) begin
            head      = exp_q[0];
            head_read = (head.kind == REQ_READ);
            // Read head waits for a free credit
            exp_valid = !(head_read && (free_credits == 0));
        end
        check_equal(64'(mem_valid), 64'(exp_valid), "mem_valid_o against model head and credits");
        xfer      = mem_valid && mem_ready;
        req_taken = core_req.valid && core_ready;
        if (xfer) begin
            // Granule of the issued address before its exact value
            if (head_read) begin
                check_equal(64'(mem_req.addr % LINE_BYTES), 64'd0, "read address off line");
            end else begin
                check_equal(64'(mem_req.addr % WORD_BYTES), 64'd0, "write address off word");
            end
            check_equal(64'(mem_req.kind), 64'(head.kind), "issued request kind");
            check_equal(64'(mem_req.addr), 64'(head.addr), "issued request address");
            check_equal(64'(mem_req.payload), 64'(head.payload), "issued request payload");
            if (head_read) begin
                free_credits--;
            end
            void'(exp_q.pop_front());
            issued++;
        end
        if (mem_rsp) begin
            free_credits++;
        end
        if (req_taken) begin
            exp_q.push_back(build_entry(core_req, next_id));
            if (core_req.kind == REQ_READ) begin
                next_id = (next_id + 1) % (1 << ID_WIDTH);
            end
            accepted++;
        end
    endtask

    // New stimulus right after the rising edge
    task automatic drive_inputs();
        core_req_t req;
        // A refused request is held unchanged
        if (!core_req.valid || req_taken) begin
            req.valid = (accepted < NUM_REQS) && (($urandom % 100) < 60);
            req.kind  = (($urandom % 2) == 0) ? REQ_READ : REQ_WRITE;
            req.addr  = $urandom;
            req.data  = {$urandom, $urandom};
            core_req <= req;
        end
        // Memory ready level with occasional long stalls
        if (stall_left != 0) begin
            stall_left--;
            mem_ready <= 1'b0;
        end else if (($urandom % 100) < 4) begin
            stall_left = 10 + ($urandom % 25);
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= (($urandom % 100) < 70);
        end
        // Responses only for reads in flight
        mem_rsp <= (free_credits < MAX_READS_OUT) && (($urandom % 100) < 30);
    endtask

    initial begin
        void'($urandom(72));
        rst_ni       = 1'b0;
        core_req     = '0;
        mem_ready    = 1'b0;
        mem_rsp      = 1'b0;
        free_credits = MAX_READS_OUT;
        next_id      = 0;
        accepted     = 0;
        issued       = 0;
        stall_left   = 0;
        req_taken    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_equal(64'(mem_valid), 64'd0, "mem_valid_o high right after reset");
        check_equal(64'(core_ready), 64'd1, "core_ready_o low right after reset");
        while (issued < NUM_REQS) begin
            @(posedge clk_i);
            drive_inputs();
            @(negedge clk_i);
            check_cycle();
        end
        check_equal(64'(exp_q.size()), 64'd0, "model queue not drained at end");
        check_equal(64'(accepted), 64'(NUM_REQS), "accepted request count at end");
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: requests were not all issued in time, %0d of %0d done",
                 issued, NUM_REQS);
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== miss_req_top.f ====
logic/cache_cfg_pkg.sv
logic/mem_req_pkg.sv
logic/miss_req_builder.sv
logic/req_fifo_reg.sv
logic/mem_req_issuer.sv
logic/miss_req_top.sv
sim/req_fifo_asserts.sv
sim/miss_req_tb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Compile the miss request path testbench with Verilator and run it.
# The exit status of the simulation binary is the result of the run.
set -e

cd "$(dirname "$0")"

TOP=miss_req_tb
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
    --top-module "${TOP}" \
    -f miss_req_top.f \
    -Mdir "${OBJ_DIR}"

"./${OBJ_DIR}/V${TOP}"
